//--- sim.f
source/boot_pkg.sv
source/flash_ctrl.sv
source/bootloader.sv
source/inst_ram.sv
source/inst_fetch.sv
source/dig_ctrl.sv
source/zhxpu_boot.sv
sim/zhxpu_boot_sva.sv
sim/zhxpu_boot_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module zhxpu_boot_tb -o zhxpu_boot_sim

./obj_dir/zhxpu_boot_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^sim passed$" sim.log; then
	exit 0
fi
exit 1

//--- sim/zhxpu_boot_tb.sv
module zhxpu_boot_tb;
	localparam int FLASH_WAIT = 3;
	localparam int RAM_AW = 6;
	localparam int IMAGE_WORDS = 1 << RAM_AW;
	localparam int FETCHES = 100;
	localparam int LIMIT = IMAGE_WORDS * (FLASH_WAIT + 4) + 400;

	logic clk;
	logic reset;
	logic [15:0] flash_data;
	logic [22:0] flash_addr;
	logic flash_ce;
	logic flash_oe;
	logic flash_we;
	logic [6:0] seg1;
	logic [6:0] seg2;
	logic [15:0] led;
	logic boot_done;
	logic inst_valid;
	logic [RAM_AW-1:0] pc;

	logic [15:0] image [IMAGE_WORDS];
	logic [15:0] last_inst;
	int exp_pc;
	int fetched;
	int tb_errors = 0;
	int mark = 0;
	int tests_run = 0;
	int tests_failed = 0;

	zhxpu_boot #(.FLASH_WAIT(FLASH_WAIT), .RAM_AW(RAM_AW)) i_dut (
		.clk(clk), .reset(reset), .flash_data(flash_data),
		.flash_addr(flash_addr), .flash_ce(flash_ce), .flash_oe(flash_oe),
		.flash_we(flash_we), .seg1(seg1), .seg2(seg2), .led(led),
		.boot_done(boot_done), .inst_valid(inst_valid), .pc(pc)
	);

	// Read-only NOR flash, answers straight from the address pins
	assign flash_data = (flash_addr < 23'(IMAGE_WORDS)) ? image[flash_addr[RAM_AW-1:0]] : 16'hffff;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("Timeout after %0d cycles, boot or fetch never finished", LIMIT);
		$display("sim failed");
		$finish;
	end

	// Branch rule: op_b jumps by its signed 11 bit offset, all else steps by one
	function automatic int predict_pc(input int p, input logic [15:0] w);
		int step;
		step = 1;
		if (w[15:11] == 5'b00010) begin
			step = int'($signed(w[10:0]));
		end
		return (p + step) & (IMAGE_WORDS - 1);
	endfunction

	task automatic fill_image();
		int off;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			if ($urandom % 4 == 0) begin
				off = int'($urandom % 17) - 8;
				image[i] = {5'b00010, 11'(off)};
			end else begin
				image[i] = 16'($urandom);
			end
		end
	endtask

	task automatic report_test(input string name);
		int total;
		int diff;
		total = tb_errors + i_dut.i_sva.fail_count;
		diff = total - mark;
		mark = total;
		tests_run++;
		if (diff == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failures", name, diff);
		end
	endtask

	// One cycle of fetch tracking, led trails the fetched word by a cycle
	task automatic track_fetch();
		@(negedge clk);
		assert (led == last_inst) else begin
			$display("[ERROR] %0t led got %h expected %h", $time, led, last_inst);
			tb_errors++;
		end
		if (inst_valid) begin
			assert (pc == RAM_AW'(exp_pc)) else begin
				$display("[ERROR] %0t pc got %0d expected %0d", $time, pc, exp_pc);
				tb_errors++;
			end
			last_inst = image[exp_pc];
			exp_pc = predict_pc(exp_pc, image[exp_pc]);
			fetched++;
		end
	endtask

	initial begin
		reset = 1'b1;
		last_inst = '0;
		exp_pc = 0;
		fetched = 0;
		void'($urandom(32'h0d30_f8b4));
		fill_image();
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		// First edge out of reset still checks the idle pins
		repeat (2) @(negedge clk);
		report_test("reset_state");

		while (!boot_done) begin
			@(negedge clk);
		end
		report_test("flash_boot");

		while (fetched < FETCHES) begin
			track_fetch();
		end
		report_test("fetch_branch");

		repeat (40) track_fetch();
		report_test("displays");

		$display("tests run %0d, tests failed %0d, failures %0d", tests_run, tests_failed, mark);
		if (mark == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- sim/zhxpu_boot_sva.sv
module zhxpu_boot_sva #(
	parameter int FLASH_WAIT = 3,
	parameter int RAM_AW = 6
) (
	input logic              clk,
	input logic              reset,
	input logic [22:0]       flash_addr,
	input logic              flash_ce,
	input logic              flash_oe,
	input logic              flash_we,
	input logic              boot_done,
	input logic              inst_valid,
	input logic [RAM_AW-1:0] pc,
	input logic [RAM_AW-1:0] init_addr,
	input logic [15:0]       inst,
	input logic [6:0]        seg1,
	input logic [6:0]        seg2,
	input logic [15:0]       led
);
	localparam int IMAGE_WORDS = 1 << RAM_AW;

	// Active low hex digits, segment a in bit 0
	localparam logic [6:0] SEG_LOW [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	int fail_count = 0;
	logic oe_q;
	int oe_low_cnt;
	int rd_cnt;
	logic [15:0] led_exp;
	logic [7:0] shown;
	logic [6:0] exp_seg1;
	logic [6:0] exp_seg2;

	assign shown = boot_done ? 8'(pc) : 8'(init_addr);
	assign exp_seg1 = SEG_LOW[shown[7:4]];
	assign exp_seg2 = SEG_LOW[shown[3:0]];

	always_ff @(posedge clk) begin
		if (reset) begin
			oe_q <= 1'b1;
			oe_low_cnt <= 0;
			rd_cnt <= 0;
			led_exp <= '0;
		end else begin
			oe_q <= flash_oe;
			oe_low_cnt <= flash_oe ? 0 : oe_low_cnt + 1;
			if (oe_q && !flash_oe) begin
				rd_cnt <= rd_cnt + 1;
			end
			led_exp <= inst_valid ? inst : led_exp;
		end
	end

	a_reset_state: assert property (@(posedge clk)
		$past(reset) |-> flash_ce && flash_oe && flash_we && !boot_done && !inst_valid)
	else begin
		$error("[ERROR] %0t reset state ce/oe/we/boot_done/inst_valid got %b%b%b%b%b expected 11100",
			$time, $sampled(flash_ce), $sampled(flash_oe), $sampled(flash_we),
			$sampled(boot_done), $sampled(inst_valid));
		fail_count++;
	end

	a_oe_length: assert property (@(posedge clk) disable iff (reset)
		$rose(flash_oe) |-> oe_low_cnt == FLASH_WAIT)
	else begin
		$error("[ERROR] %0t flash_oe low cycles got %0d expected %0d",
			$time, $sampled(oe_low_cnt), FLASH_WAIT);
		fail_count++;
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		!flash_oe && $past(!flash_oe) |-> $stable(flash_addr))
	else begin
		$error("flash_addr changed while flash_oe was low, at %0t", $time);
		fail_count++;
	end

	// Reads walk the image in order, only while booting
	a_read_addr: assert property (@(posedge clk) disable iff (reset)
		$fell(flash_oe) |-> flash_addr == 23'(rd_cnt) && !boot_done)
	else begin
		$error("[ERROR] %0t flash_addr got %0h expected %0h",
			$time, $sampled(flash_addr), $sampled(rd_cnt));
		fail_count++;
	end

	a_read_count: assert property (@(posedge clk) disable iff (reset)
		$rose(boot_done) |-> rd_cnt == IMAGE_WORDS)
	else begin
		$error("[ERROR] %0t flash read count got %0d expected %0d",
			$time, $sampled(rd_cnt), IMAGE_WORDS);
		fail_count++;
	end

	a_flash_idle: assert property (@(posedge clk) disable iff (reset)
		boot_done |-> flash_oe && flash_ce)
	else begin
		$error("flash read started after boot_done, at %0t", $time);
		fail_count++;
	end

	a_fetch_rate: assert property (@(posedge clk) disable iff (reset)
		$past(inst_valid, 2) |-> inst_valid && !$past(inst_valid))
	else begin
		$error("inst_valid did not repeat every two cycles, at %0t", $time);
		fail_count++;
	end

	a_seg1: assert property (@(posedge clk) disable iff (reset) seg1 == exp_seg1)
	else begin
		$error("[ERROR] %0t seg1 got %h expected %h", $time, $sampled(seg1), $sampled(exp_seg1));
		fail_count++;
	end

	a_seg2: assert property (@(posedge clk) disable iff (reset) seg2 == exp_seg2)
	else begin
		$error("[ERROR] %0t seg2 got %h expected %h", $time, $sampled(seg2), $sampled(exp_seg2));
		fail_count++;
	end

	a_led: assert property (@(posedge clk) disable iff (reset) led == led_exp)
	else begin
		$error("[ERROR] %0t led got %h expected %h", $time, $sampled(led), $sampled(led_exp));
		fail_count++;
	end

endmodule

bind zhxpu_boot zhxpu_boot_sva #(.FLASH_WAIT(FLASH_WAIT), .RAM_AW(RAM_AW)) i_sva (
	.clk(clk), .reset(reset),
	.flash_addr(flash_addr), .flash_ce(flash_ce), .flash_oe(flash_oe), .flash_we(flash_we),
	.boot_done(boot_done), .inst_valid(inst_valid), .pc(pc),
	.init_addr(init_addr), .inst(inst),
	.seg1(seg1), .seg2(seg2), .led(led)
);

//--- source/zhxpu_boot.sv
module zhxpu_boot
	import boot_pkg::*;
#(
	parameter int FLASH_WAIT = 3,
	parameter int RAM_AW = 6
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [WORD_W-1:0] flash_data,
	output logic [22:0]       flash_addr,
	output logic              flash_ce,
	output logic              flash_oe,
	output logic              flash_we,
	output logic [6:0]        seg1,
	output logic [6:0]        seg2,
	output logic [15:0]       led,
	output logic              boot_done,
	output logic              inst_valid,
	output logic [RAM_AW-1:0] pc
);
	logic flash_need_to_work;
	logic flash_work_done;
	logic [RAM_AW-1:0] flash_word_addr;
	logic [WORD_W-1:0] flash_word;
	logic init_wr;
	logic [RAM_AW-1:0] init_addr;
	logic [WORD_W-1:0] init_data;
	logic ram_need_to_work;
	logic ram_work_done;
	logic [WORD_W-1:0] ram_result;
	logic [WORD_W-1:0] inst;
	logic [7:0] disp_byte;

	// Never written
	assign flash_we = 1'b1;

	flash_ctrl #(.FLASH_WAIT(FLASH_WAIT), .RAM_AW(RAM_AW)) __flash_ctrl (
		.clk(clk), .reset(reset),
		.need_to_work(flash_need_to_work), .addr(flash_word_addr),
		.flash_data(flash_data), .flash_addr(flash_addr),
		.flash_ce(flash_ce), .flash_oe(flash_oe),
		.data(flash_word), .work_done(flash_work_done)
	);

	bootloader #(.RAM_AW(RAM_AW)) __bootloader (
		.clk(clk), .reset(reset),
		.flash_done(flash_work_done), .flash_data(flash_word),
		.need_to_work(flash_need_to_work), .caddr(flash_word_addr),
		.init_wr(init_wr), .init_addr(init_addr), .init_data(init_data),
		.boot_done(boot_done)
	);

	inst_ram #(.RAM_AW(RAM_AW)) __inst_ram (
		.clk(clk),
		.init_wr(init_wr), .init_addr(init_addr), .init_data(init_data),
		.need_to_work(ram_need_to_work), .addr(pc),
		.work_done(ram_work_done), .result(ram_result)
	);

	inst_fetch #(.RAM_AW(RAM_AW)) __inst_fetch (
		.clk(clk), .reset(reset), .boot_done(boot_done),
		.ram_work_done(ram_work_done), .ram_result(ram_result),
		.ram_need_to_work(ram_need_to_work),
		.pc(pc), .inst(inst), .inst_valid(inst_valid)
	);

	// Boot address while loading, program counter afterwards
	assign disp_byte = boot_done ? 8'(pc) : 8'(init_addr);

	dig_ctrl __dig_ctrl_1 (.dig(disp_byte[7:4]), .light(seg1));
	dig_ctrl __dig_ctrl_2 (.dig(disp_byte[3:0]), .light(seg2));

	always_ff @(posedge clk) begin
		if (reset) begin
			led <= '0;
		end else if (inst_valid) begin
			led <= inst;
		end
	end

endmodule

//--- source/dig_ctrl.sv
module dig_ctrl (
	input  logic [3:0] dig,
	output logic [6:0] light
);
	// Segments g..a, lit when set
	logic [6:0] seg;

	always_comb begin
		case (dig)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
	end

	// Display is active low
	assign light = ~seg;

endmodule

//--- source/inst_fetch.sv
module inst_fetch
	import boot_pkg::*;
#(
	parameter int RAM_AW = 6
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              boot_done,
	input  logic              ram_work_done,
	input  logic [WORD_W-1:0] ram_result,
	output logic              ram_need_to_work,
	output logic [RAM_AW-1:0] pc,
	output logic [WORD_W-1:0] inst,
	output logic              inst_valid
);
	fetch_state_t state;
	opcode_t op;
	logic [WORD_W-1:0] offset;
	logic [RAM_AW-1:0] next_pc;

	function automatic opcode_t classify(input logic [4:0] top);
		case (top)
			op_nop:  return op_nop;
			op_b:    return op_b;
			default: return op_other;
		endcase
	endfunction

	assign inst = ram_result;
	assign inst_valid = (state == fe_wait) && ram_work_done;

	always_comb begin
		op = classify(inst[WORD_W-1:WORD_W-5]);
		offset = {{(WORD_W - 11){inst[10]}}, inst[10:0]};
		case (op)
			// Relative to the branch's own address, wraps at image size
			op_b:    next_pc = pc + offset[RAM_AW-1:0];
			default: next_pc = pc + 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fe_off;
			pc <= '0;
			ram_need_to_work <= 1'b0;
		end else begin
			case (state)
				fe_off: begin
					if (boot_done) begin
						ram_need_to_work <= 1'b1;
						state <= fe_request;
					end
				end
				fe_request: begin
					ram_need_to_work <= 1'b0;
					state <= fe_wait;
				end
				fe_wait: begin
					if (ram_work_done) begin
						pc <= next_pc;
						ram_need_to_work <= 1'b1;
						state <= fe_request;
					end
				end
				default: state <= fe_off;
			endcase
		end
	end

endmodule

//--- source/inst_ram.sv
module inst_ram
	import boot_pkg::*;
#(
	parameter int RAM_AW = 6
) (
	input  logic              clk,
	input  logic              init_wr,
	input  logic [RAM_AW-1:0] init_addr,
	input  logic [WORD_W-1:0] init_data,
	input  logic              need_to_work,
	input  logic [RAM_AW-1:0] addr,
	output logic              work_done,
	output logic [WORD_W-1:0] result
);
	localparam int IMAGE_WORDS = 1 << RAM_AW;

	logic [WORD_W-1:0] mem [IMAGE_WORDS];

	// Boot side write port
	always_ff @(posedge clk) begin
		if (init_wr) begin
			mem[init_addr] <= init_data;
		end
	end

	// Fetch side read, one cycle latency
	always_ff @(posedge clk) begin
		if (need_to_work) begin
			result <= mem[addr];
		end
	end

	always_ff @(posedge clk) begin
		work_done <= need_to_work;
	end

endmodule

//--- source/bootloader.sv
module bootloader
	import boot_pkg::*;
#(
	parameter int RAM_AW = 6
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              flash_done,
	input  logic [WORD_W-1:0] flash_data,
	output logic              need_to_work,
	output logic [RAM_AW-1:0] caddr,
	output logic              init_wr,
	output logic [RAM_AW-1:0] init_addr,
	output logic [WORD_W-1:0] init_data,
	output logic              boot_done
);
	localparam int IMAGE_WORDS = 1 << RAM_AW;
	localparam logic [RAM_AW-1:0] LAST_ADDR = RAM_AW'(IMAGE_WORDS - 1);

	boot_state_t state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bt_request;
			need_to_work <= 1'b0;
			caddr <= '0;
			init_wr <= 1'b0;
			init_addr <= '0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				bt_request: begin
					need_to_work <= 1'b1;
					if (flash_done) begin
						need_to_work <= 1'b0;
						init_wr <= 1'b1;
						init_addr <= caddr;
						state <= bt_write;
					end
				end
				bt_write: begin
					init_wr <= 1'b0;
					if (caddr == LAST_ADDR) begin
						boot_done <= 1'b1;
						state <= bt_finished;
					end else begin
						caddr <= caddr + 1'b1;
						need_to_work <= 1'b1;
						state <= bt_request;
					end
				end
				// Image copied, stay here until reset
				bt_finished: begin
					need_to_work <= 1'b0;
				end
				default: state <= bt_finished;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == bt_request && flash_done) begin
			init_data <= flash_data;
		end
	end

endmodule

//--- source/flash_ctrl.sv
module flash_ctrl
	import boot_pkg::*;
#(
	parameter int FLASH_WAIT = 3,
	parameter int RAM_AW = 6
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              need_to_work,
	input  logic [RAM_AW-1:0] addr,
	input  logic [WORD_W-1:0] flash_data,
	output logic [22:0]       flash_addr,
	output logic              flash_ce,
	output logic              flash_oe,
	output logic [WORD_W-1:0] data,
	output logic              work_done
);
	localparam int CNT_W = $clog2(FLASH_WAIT + 1);

	flash_state_t state;
	logic [CNT_W-1:0] wait_cnt;
	logic last_wait;

	assign last_wait = (state == fl_wait) && (wait_cnt == CNT_W'(FLASH_WAIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fl_idle;
			wait_cnt <= '0;
			flash_addr <= '0;
			flash_ce <= 1'b1;
			flash_oe <= 1'b1;
			work_done <= 1'b0;
		end else begin
			case (state)
				fl_idle: begin
					if (need_to_work) begin
						// Word address, zero-extended onto the flash bus
						flash_addr <= 23'(addr);
						flash_ce <= 1'b0;
						flash_oe <= 1'b0;
						wait_cnt <= '0;
						state <= fl_wait;
					end
				end
				fl_wait: begin
					if (last_wait) begin
						flash_ce <= 1'b1;
						flash_oe <= 1'b1;
						work_done <= 1'b1;
						state <= fl_done;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				fl_done: begin
					work_done <= 1'b0;
					state <= fl_idle;
				end
				default: state <= fl_idle;
			endcase
		end
	end

	// Sample at the end of the output-enable window
	always_ff @(posedge clk) begin
		if (last_wait) begin
			data <= flash_data;
		end
	end

endmodule

//--- source/boot_pkg.sv
package boot_pkg;

	// Flash word and instruction width
	localparam int WORD_W = 16;

	// Top five bits of an instruction
	typedef enum logic [4:0] {
		op_other = 5'b00000,
		op_nop   = 5'b00001,
		op_b     = 5'b00010
	} opcode_t;

	typedef enum logic [1:0] {
		fl_idle,
		fl_wait,
		fl_done
	} flash_state_t;

	typedef enum logic [1:0] {
		bt_request,
		bt_write,
		bt_finished
	} boot_state_t;

	typedef enum logic [1:0] {
		fe_off,
		fe_request,
		fe_wait
	} fetch_state_t;

endpackage
